/* logic/arm_pkg.sv */
// Execute core shared types
package arm_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [3:0]  flags_t;   // N Z C V, N in bit 3

  // Instruction field positions, given as the top bit of each field
  localparam int COND_MSB = 31;
  localparam int MODE_MSB = 26;
  localparam int OP_MSB   = 24;
  localparam int S_BIT    = 20;
  localparam int RN_MSB   = 19;
  localparam int RD_MSB   = 15;

  typedef enum logic [3:0] {
    op_and = 4'd0,
    op_or  = 4'd1,
    op_sub = 4'd2,
    op_add = 4'd3,
    op_mov = 4'd4   // Passes the shifted operand
  } alu_op_e;

  typedef enum logic [3:0] {
    cond_eq, cond_ne, cond_cs, cond_cc,
    cond_mi, cond_pl, cond_vs, cond_vc,
    cond_hi, cond_ls, cond_ge, cond_lt,
    cond_gt, cond_le, cond_al, cond_nv
  } cond_e;

  typedef enum logic [1:0] {
    am_rot_imm   = 2'd0,
    am_reg       = 2'd1,
    am_zext_imm  = 2'd2,
    am_shift_reg = 2'd3
  } operand_mode_e;

  typedef enum logic [1:0] {
    sh_lsl = 2'd0,
    sh_lsr = 2'd1,
    sh_asr = 2'd2,
    sh_ror = 2'd3
  } shift_type_e;

endpackage

/* logic/reg_file.sv */
// Sixteen entry register file
`timescale 1ns/10ps

module reg_file import arm_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     wr_en,
  input  reg_idx_t wr_idx,
  input  word_t    wr_data,
  input  reg_idx_t rd_idx_a,
  input  reg_idx_t rd_idx_b,
  output word_t    rd_data_a,
  output word_t    rd_data_b
);

  word_t regs [16];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Reads show the stored value, a same-cycle write is seen through forwarding
  assign rd_data_a = regs[rd_idx_a];   // Rn port
  assign rd_data_b = regs[rd_idx_b];   // Rm port

  wr_idx_known_a: assert property (
    @(posedge clk) disable iff (reset)
    wr_en |-> !$isunknown(wr_idx)
  ) else $error("register write with unknown index");

endmodule

/* logic/decode_stage.sv */
// Decode stage and ID/EX register
`timescale 1ns/10ps

module decode_stage import arm_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          instr_valid,
  input  word_t         instr,
  input  word_t         rd_data_a,
  input  word_t         rd_data_b,
  input  logic          ex_wr_en,
  input  reg_idx_t      ex_rd,
  input  word_t         ex_result,
  output reg_idx_t      rd_idx_a,
  output reg_idx_t      rd_idx_b,
  output logic          id_valid,
  output cond_e         id_cond,
  output operand_mode_e id_mode,
  output alu_op_e       id_op,
  output logic          id_set_flags,
  output reg_idx_t      id_rd,
  output logic [11:0]   id_operand,
  output word_t         id_rn_val,
  output word_t         id_rm_val
);

  logic  fwd_rn;
  logic  fwd_rm;
  word_t rn_val;
  word_t rm_val;

  assign rd_idx_a = instr[RN_MSB -: 4];   // Rn
  assign rd_idx_b = instr[3:0];           // Rm

  // The instruction in execute writes at the coming edge, so take its result now
  assign fwd_rn = ex_wr_en && (ex_rd == rd_idx_a);
  assign fwd_rm = ex_wr_en && (ex_rd == rd_idx_b);

  assign rn_val = fwd_rn ? ex_result : rd_data_a;
  assign rm_val = fwd_rm ? ex_result : rd_data_b;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_valid <= 1'b0;
    end else begin
      id_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      id_cond      <= cond_e'(instr[COND_MSB -: 4]);
      id_mode      <= operand_mode_e'(instr[MODE_MSB -: 2]);   // Bit 27 ignored
      id_op        <= alu_op_e'(instr[OP_MSB -: 4]);
      id_set_flags <= instr[S_BIT];
      id_rd        <= instr[RD_MSB -: 4];
      id_operand   <= instr[11:0];
      id_rn_val    <= rn_val;
      id_rm_val    <= rm_val;
    end
  end

endmodule

/* logic/operand_shifter.sv */
// Second operand shifter
`timescale 1ns/10ps

module operand_shifter import arm_pkg::*; (
  input  operand_mode_e mode,
  input  logic [11:0]   operand,
  input  word_t         rm_val,
  output word_t         shifter_out
);

  word_t       imm_word;
  logic [4:0]  rot_amt;
  logic [4:0]  sh_amt;
  shift_type_e sh_type;
  logic [63:0] imm_pair;
  logic [63:0] rm_pair;

  assign imm_word = {24'b0, operand[7:0]};
  assign rot_amt  = {operand[11:8], 1'b0};   // Twice the rotate field
  assign sh_amt   = operand[11:7];
  assign sh_type  = shift_type_e'(operand[6:5]);

  // Doubled words turn a right shift into a rotate
  assign imm_pair = {imm_word, imm_word} >> rot_amt;
  assign rm_pair  = {rm_val, rm_val} >> sh_amt;

  always_comb begin
    shifter_out = '0;
    case (mode)
      am_rot_imm:  shifter_out = imm_pair[31:0];
      am_reg:      shifter_out = rm_val;
      am_zext_imm: shifter_out = {20'b0, operand};
      am_shift_reg: begin
        // Zero amount leaves Rm as it is for every type
        case (sh_type)
          sh_lsl:  shifter_out = rm_val << sh_amt;
          sh_lsr:  shifter_out = rm_val >> sh_amt;
          sh_asr:  shifter_out = $signed(rm_val) >>> sh_amt;
          sh_ror:  shifter_out = rm_pair[31:0];
          default: shifter_out = '0;
        endcase
      end
      default: shifter_out = '0;
    endcase
  end

endmodule

/* logic/alu.sv */
// ALU with flag generation
`timescale 1ns/10ps

module alu import arm_pkg::*; (
  input  alu_op_e op,
  input  word_t   a,
  input  word_t   b,
  input  flags_t  flags_in,
  output word_t   result,
  output flags_t  flags_out
);

  logic [32:0] sum;
  logic [32:0] diff;
  logic        c_new;
  logic        v_new;

  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} - {1'b0, b};

  always_comb begin
    result = '0;
    c_new  = flags_in[1];   // C and V held unless arithmetic
    v_new  = flags_in[0];
    case (op)
      op_and: result = a & b;
      op_or:  result = a | b;
      op_sub: begin
        result = diff[31:0];
        c_new  = ~diff[32];   // Set when no borrow
        v_new  = (a[31] != b[31]) && (diff[31] != a[31]);
      end
      op_add: begin
        result = sum[31:0];
        c_new  = sum[32];
        v_new  = (a[31] == b[31]) && (sum[31] != a[31]);
      end
      op_mov: result = b;
      default: result = '0;
    endcase
  end

  assign flags_out = {result[31], (result == '0), c_new, v_new};

endmodule

/* logic/cond_flags.sv */
// Flag register and condition check
`timescale 1ns/10ps

module cond_flags import arm_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  cond_e  cond,
  input  logic   flags_wr,
  input  flags_t flags_next,
  output flags_t flags,
  output logic   cond_pass
);

  logic n;
  logic z;
  logic c;
  logic v;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags <= '0;
    end else if (flags_wr) begin
      flags <= flags_next;
    end
  end

  assign {n, z, c, v} = flags;

  always_comb begin
    case (cond)
      cond_eq: cond_pass = z;
      cond_ne: cond_pass = !z;
      cond_cs: cond_pass = c;
      cond_cc: cond_pass = !c;
      cond_mi: cond_pass = n;
      cond_pl: cond_pass = !n;
      cond_vs: cond_pass = v;
      cond_vc: cond_pass = !v;
      cond_hi: cond_pass = c && !z;        // Unsigned higher
      cond_ls: cond_pass = !c || z;
      cond_ge: cond_pass = (n == v);       // Signed compare
      cond_lt: cond_pass = (n != v);
      cond_gt: cond_pass = !z && (n == v);
      cond_le: cond_pass = z || (n != v);
      cond_al: cond_pass = 1'b1;
      default: cond_pass = 1'b0;           // NV never runs
    endcase
  end

  // A flag change must come from a write in the cycle before
  flags_hold_a: assert property (
    @(posedge clk) disable iff (reset)
    !$stable(flags) |-> $past(flags_wr)
  ) else $error("flags changed without a flag write");

endmodule

/* logic/exec_stage.sv */
// Execute stage with write-back
`timescale 1ns/10ps

module exec_stage import arm_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          id_valid,
  input  cond_e         id_cond,
  input  operand_mode_e id_mode,
  input  alu_op_e       id_op,
  input  logic          id_set_flags,
  input  reg_idx_t      id_rd,
  input  logic [11:0]   id_operand,
  input  word_t         id_rn_val,
  input  word_t         id_rm_val,
  output logic          ex_wr_en,
  output reg_idx_t      ex_rd,
  output word_t         ex_result,
  output logic          done,
  output logic          executed,
  output word_t         result,
  output reg_idx_t      result_rd,
  output flags_t        flags
);

  word_t  shifter_out;
  word_t  alu_result;
  flags_t alu_flags;
  logic   cond_pass;
  logic   flags_wr;

  operand_shifter shifter0 (
    .mode        (id_mode),
    .operand     (id_operand),
    .rm_val      (id_rm_val),
    .shifter_out (shifter_out)
  );

  alu alu0 (
    .op        (id_op),
    .a         (id_rn_val),
    .b         (shifter_out),
    .flags_in  (flags),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  cond_flags flags0 (
    .clk        (clk),
    .reset      (reset),
    .cond       (id_cond),
    .flags_wr   (flags_wr),
    .flags_next (alu_flags),
    .flags      (flags),
    .cond_pass  (cond_pass)
  );

  assign ex_wr_en  = id_valid && cond_pass;   // Also drives the register file write
  assign ex_rd     = id_rd;
  assign ex_result = alu_result;
  assign flags_wr  = ex_wr_en && id_set_flags;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      done     <= 1'b0;
      executed <= 1'b0;
    end else begin
      done     <= id_valid;
      executed <= ex_wr_en;
    end
  end

  // Value is reported even when the condition failed
  always_ff @(posedge clk) begin
    result    <= alu_result;
    result_rd <= id_rd;
  end

  executed_done_a: assert property (
    @(posedge clk) disable iff (reset)
    executed |-> done
  ) else $error("executed without done");

endmodule

/* logic/arm_exec_core.sv */
// Two-stage execute core
`timescale 1ns/10ps

module arm_exec_core import arm_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     instr_valid,
  input  word_t    instr,
  output logic     done,
  output logic     executed,
  output word_t    result,
  output reg_idx_t result_rd,
  output flags_t   flags
);

  reg_idx_t      rd_idx_a;
  reg_idx_t      rd_idx_b;
  word_t         rd_data_a;
  word_t         rd_data_b;
  logic          ex_wr_en;
  reg_idx_t      ex_rd;
  word_t         ex_result;
  logic          id_valid;
  cond_e         id_cond;
  operand_mode_e id_mode;
  alu_op_e       id_op;
  logic          id_set_flags;
  reg_idx_t      id_rd;
  logic [11:0]   id_operand;
  word_t         id_rn_val;
  word_t         id_rm_val;

  decode_stage decode0 (
    .clk (clk), .reset (reset), .instr_valid (instr_valid), .instr (instr),
    .rd_data_a (rd_data_a), .rd_data_b (rd_data_b),
    .ex_wr_en (ex_wr_en), .ex_rd (ex_rd), .ex_result (ex_result),
    .rd_idx_a (rd_idx_a), .rd_idx_b (rd_idx_b), .id_valid (id_valid),
    .id_cond (id_cond), .id_mode (id_mode), .id_op (id_op),
    .id_set_flags (id_set_flags), .id_rd (id_rd), .id_operand (id_operand),
    .id_rn_val (id_rn_val), .id_rm_val (id_rm_val)
  );

  // Write port is fed straight from the execute stage
  reg_file regs0 (
    .clk (clk), .reset (reset),
    .wr_en (ex_wr_en), .wr_idx (ex_rd), .wr_data (ex_result),
    .rd_idx_a (rd_idx_a), .rd_idx_b (rd_idx_b),
    .rd_data_a (rd_data_a), .rd_data_b (rd_data_b)
  );

  exec_stage exec0 (
    .clk (clk), .reset (reset), .id_valid (id_valid), .id_cond (id_cond),
    .id_mode (id_mode), .id_op (id_op), .id_set_flags (id_set_flags),
    .id_rd (id_rd), .id_operand (id_operand),
    .id_rn_val (id_rn_val), .id_rm_val (id_rm_val),
    .ex_wr_en (ex_wr_en), .ex_rd (ex_rd), .ex_result (ex_result),
    .done (done), .executed (executed), .result (result),
    .result_rd (result_rd), .flags (flags)
  );

endmodule

/* tests/tb_clock.sv */
// Testbench clock source
`timescale 1ns/10ps

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;   // 8 ns period

endmodule

/* tests/arm_exec_core_tb.sv */
// Execute core testbench
`timescale 1ns/10ps

module arm_exec_core_tb import arm_pkg::*; ();

  typedef struct packed {
    logic     valid;
    logic     exec;
    word_t    result;
    reg_idx_t rd;
    flags_t   flags;
  } expect_t;

  logic     clk;
  logic     reset;
  logic     instr_valid;
  word_t    instr;
  logic     done;
  logic     executed;
  word_t    result;
  reg_idx_t result_rd;
  flags_t   flags;

  expect_t  exp_q[$];    // One entry per driven cycle
  word_t    m_regs [16];
  flags_t   m_flags;
  integer   seed;
  int       errors;
  int       tests_run;
  int       checked;
  int       pending;     // Issued instructions still waiting for done

  tb_clock clock0 (.clk(clk));

  arm_exec_core dut0 (
    .clk (clk), .reset (reset), .instr_valid (instr_valid), .instr (instr),
    .done (done), .executed (executed), .result (result),
    .result_rd (result_rd), .flags (flags)
  );

  function automatic word_t encode(logic [3:0] cond, logic [1:0] mode, logic [3:0] op,
                                   logic s, reg_idx_t rn, reg_idx_t rd, logic [11:0] operand);
    return {cond, 1'b0, mode, op, s, rn, rd, operand};
  endfunction

  function automatic word_t rotate_right(word_t x, int n);
    for (int i = 0; i < n; i++) begin
      x = {x[0], x[31:1]};
    end
    return x;
  endfunction

  function automatic word_t operand_model(word_t ins, word_t rm_val);
    word_t v;
    int    amt;
    amt = ins[11:7];
    v = rm_val;
    case (ins[26:25])
      2'd0: v = rotate_right({24'b0, ins[7:0]}, 2 * int'(ins[11:8]));
      2'd1: v = rm_val;
      2'd2: v = {20'b0, ins[11:0]};
      default: begin
        case (ins[6:5])
          2'd0: v = rm_val << amt;
          2'd1: v = rm_val >> amt;
          2'd2: begin
            for (int i = 0; i < amt; i++) begin
              v = {v[31], v[31:1]};   // Sign bit refills the top
            end
          end
          default: v = rotate_right(rm_val, amt);
        endcase
      end
    endcase
    return v;
  endfunction

  function automatic void alu_model(input logic [3:0] op, input word_t a, input word_t b,
                                    input flags_t f, output word_t res, output flags_t nf);
    logic [32:0] wide;
    logic        c;
    logic        v;
    c = f[1];
    v = f[0];
    res = '0;
    case (op)
      4'd0: res = a & b;
      4'd1: res = a | b;
      4'd2: begin
        res = a - b;
        c = (a >= b);
        v = (a[31] != b[31]) && (res[31] != a[31]);
      end
      4'd3: begin
        wide = {1'b0, a} + {1'b0, b};
        res = wide[31:0];
        c = wide[32];
        v = (a[31] == b[31]) && (res[31] != a[31]);
      end
      4'd4: res = b;
      default: res = '0;   // Unused opcodes
    endcase
    nf = {res[31], res == 32'd0, c, v};
  endfunction

  function automatic logic cond_model(logic [3:0] cond, flags_t f);
    logic n;
    logic z;
    logic c;
    logic v;
    {n, z, c, v} = f;
    case (cond)
      cond_eq: return z;
      cond_ne: return !z;
      cond_cs: return c;
      cond_cc: return !c;
      cond_mi: return n;
      cond_pl: return !n;
      cond_vs: return v;
      cond_vc: return !v;
      cond_hi: return c && !z;
      cond_ls: return !c || z;
      cond_ge: return n == v;
      cond_lt: return n != v;
      cond_gt: return !z && (n == v);
      cond_le: return z || (n != v);
      cond_al: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic report_error(string what, word_t got, word_t want);
    $display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
    errors++;
  endtask

  // Outputs seen now belong to the cycle driven two falling edges ago
  task automatic check_outputs();
    expect_t e;
    if (exp_q.size() >= 2) begin
      e = exp_q.pop_front();
      checked++;
      if (done !== e.valid) report_error("done", done, e.valid);
      if (e.valid) begin
        if (done === 1'b1) pending--;
        if (executed !== e.exec) report_error("executed", executed, e.exec);
        if (result !== e.result) report_error("result", result, e.result);
        if (result_rd !== e.rd) report_error("result_rd", result_rd, e.rd);
      end else if (executed !== 1'b0) begin
        report_error("executed", executed, 1'b0);
      end
      if (flags !== e.flags) report_error("flags", flags, e.flags);
    end
  endtask

  task automatic step(input logic valid, input word_t ins);
    expect_t e;
    word_t   op2;
    word_t   res;
    flags_t  nf;
    logic    pass;
    check_outputs();
    instr_valid = valid;
    instr = ins;
    e = '0;
    e.valid = valid;
    if (valid) begin
      op2 = operand_model(ins, m_regs[ins[3:0]]);
      alu_model(ins[24:21], m_regs[ins[19:16]], op2, m_flags, res, nf);
      pass = cond_model(ins[31:28], m_flags);
      if (pass) begin
        m_regs[ins[15:12]] = res;
        if (ins[20]) m_flags = nf;
      end
      e.exec = pass;
      e.result = res;
      e.rd = ins[15:12];
      pending++;
    end
    e.flags = m_flags;
    exp_q.push_back(e);
    @(negedge clk);
  endtask

  task automatic drain();
    int wait_cycles;
    wait_cycles = 0;
    while (pending > 0 && wait_cycles < 10) begin
      step(1'b0, '0);
      wait_cycles++;
    end
    if (pending > 0) begin
      $display("timeout: %0d instructions never reported done", pending);
      $display("TESTS FAILED");
      $finish;
    end
  endtask

  // OR with zero copies each register onto result
  task automatic read_back();
    for (int i = 0; i < 16; i++) begin
      step(1'b1, encode(cond_al, am_zext_imm, op_or, 1'b0, i[3:0], i[3:0], 12'h000));
    end
  endtask

  task automatic finish_test(string name, int err_start);
    tests_run++;
    if (errors == err_start) $display("test %0d %s: ok", tests_run, name);
    else $display("test %0d %s: %0d errors", tests_run, name, errors - err_start);
  endtask

  task automatic test_reset_and_load();
    int    err_start;
    word_t r;
    err_start = errors;
    if (done !== 1'b0) report_error("done after reset", done, 1'b0);
    if (executed !== 1'b0) report_error("executed after reset", executed, 1'b0);
    if (flags !== 4'h0) report_error("flags after reset", flags, 4'h0);
    repeat (4) step(1'b0, '0);
    for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      step(1'b1, encode(cond_al, am_zext_imm, op_mov, 1'b0, r[19:16], i[3:0], r[11:0]));
    end
    drain();
    finish_test("reset and register load", err_start);
  endtask

  task automatic test_random_al();
    int    err_start;
    word_t r;
    err_start = errors;
    for (int i = 0; i < 300; i++) begin
      r = $random(seed);
      r[31:28] = cond_al;
      step(1'b1, r);
    end
    drain();
    finish_test("random unconditional", err_start);
  endtask

  task automatic test_dependent_chains();
    int          err_start;
    word_t       r;
    reg_idx_t    prev_rd;
    reg_idx_t    rn;
    logic [1:0]  mode;
    logic [11:0] operand;
    err_start = errors;
    prev_rd = 4'd0;
    for (int i = 0; i < 150; i++) begin
      r = $random(seed);
      operand = r[27:16];
      if (r[0]) begin
        rn = prev_rd;           // Depends through Rn
        mode = r[2:1];
      end else begin
        rn = r[11:8];
        mode = {r[1], 1'b1};    // Register or shifted register
        operand[3:0] = prev_rd;
      end
      step(1'b1, encode(cond_al, mode, 4'({$random(seed)} % 5), r[3], rn, r[15:12],
                        operand));
      prev_rd = r[15:12];
    end
    drain();
    finish_test("dependent chains", err_start);
  endtask

  task automatic test_conditions();
    int    err_start;
    word_t r;
    err_start = errors;
    for (int i = 0; i < 300; i++) begin
      r = $random(seed);
      step(1'b1, r);
    end
    read_back();
    drain();
    finish_test("condition codes", err_start);
  endtask

  task automatic test_valid_gaps();
    int    err_start;
    word_t r;
    word_t gap;
    err_start = errors;
    for (int i = 0; i < 300; i++) begin
      r = $random(seed);
      gap = $random(seed);
      step(gap[1:0] != 2'b00, r);   // Instruction bits still toggle when idle
    end
    read_back();
    drain();
    finish_test("valid gaps", err_start);
  endtask

  initial begin
    seed = 88;
    errors = 0;
    tests_run = 0;
    checked = 0;
    pending = 0;
    m_flags = '0;
    for (int i = 0; i < 16; i++) begin
      m_regs[i] = '0;
    end
    reset = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_reset_and_load();
    test_random_al();
    test_dependent_chains();
    test_conditions();
    test_valid_gaps();

    $display("%0d tests, %0d cycles compared, %0d errors", tests_run, checked, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
logic/arm_pkg.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/operand_shifter.sv
logic/alu.sv
logic/cond_flags.sv
logic/exec_stage.sv
logic/arm_exec_core.sv
tests/tb_clock.sv
tests/arm_exec_core_tb.sv
